/* snd_consts.svh */
// fixed constants only; assumes 8-bit CPU data, 16-bit addresses and 4.4 unsigned gains
`ifndef SND_CONSTS_SVH
`define SND_CONSTS_SVH

// work RAM, 2 KB
`define SND_RAM_AW 11

// device field, address bits 13..11 when bits 15..14 are clear
`define SND_MAP_RAM   3'd0
`define SND_MAP_OPN   3'd1
`define SND_MAP_OPL   3'd2
`define SND_MAP_LATCH 3'd6 // read only, clears NMI
`define SND_MAP_OKI   3'd7

// 4.4 gains, 8'h10 is unity
`define SND_OPL_GAIN 8'h10
`define SND_PCM_GAIN 8'h10
`define SND_PSG_GAIN 8'h10

// OPN gain picked by fxlevel
`define SND_FX_GAIN0 8'h18
`define SND_FX_GAIN1 8'h20
`define SND_FX_GAIN2 8'h28
`define SND_FX_GAIN3 8'h30

`define SND_DCRM_SHIFT 6 // time constant of 64 samples

`endif

/* snd_bus_pkg.sv */
// sound CPU bus and device select types; 16-bit address and 8-bit data only, no wait states
package snd_bus_pkg;

    // one CPU bus cycle, held by the CPU until rdy is high
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata; // CPU write data
        logic        rnw;   // 1 read, 0 write
    } cpu_bus_t;

    // selects towards the external sound chips
    typedef struct packed {
        logic opn;
        logic opl;
        logic oki;
        logic oki_wrn; // active low write strobe of the ADPCM chip
    } dev_sel_t;

    // read data coming back from the sound chips
    typedef struct packed {
        logic [7:0] opn;
        logic [7:0] opl;
        logic [7:0] oki;
    } dev_rd_t;

endpackage

/* snd_audio_pkg.sv */
// audio types; channels are 16-bit signed except the raw PSG, which is 10-bit unsigned
package snd_audio_pkg;

    typedef logic signed [15:0] smp_t;
    typedef logic        [9:0]  psg_t;  // raw PSG, unsigned with DC offset
    typedef logic        [7:0]  gain_t; // 4.4 fixed point

    // channels as they come from the chips
    typedef struct packed {
        smp_t opn;
        smp_t opl;
        smp_t adpcm;
        psg_t psg;
    } chan_in_t;

    // mixer inputs, PSG already DC free
    typedef struct packed {
        smp_t opn;
        smp_t opl;
        smp_t pcm;
        smp_t psg;
    } mix_in_t;

    typedef struct packed {
        gain_t opn;
        gain_t opl;
        gain_t pcm;
        gain_t psg;
    } gain_set_t;

endpackage

/* snd_ctrl.sv */
// bus glue for a 6502-style CPU; device read data is one cycle late and ROM stalls via rdy only
`include "snd_consts.svh"

module snd_ctrl import snd_bus_pkg::*; #(
    parameter int BANKS = 0 // 1 enables the bank register on address bit 15
) (
    input  logic       clk,
    input  logic       rst,
    input  cpu_bus_t   bus,
    input  logic       snreq,    // sound request from main CPU
    input  logic [7:0] latch,
    input  logic [7:0] rom_data,
    input  logic       rom_ok,
    input  logic [7:0] ram_dout,
    input  dev_rd_t    dev_rd,
    input  logic       opn_irqn,
    input  logic       opl_irqn,
    output logic       rom_cs,
    output logic       ram_we,
    output dev_sel_t   dev_sel,
    output logic [7:0] cpu_din,
    output logic       rdy,
    output logic       nmin,
    output logic       irqn,
    output logic       snd_bank
);

    logic       ram_cs;
    logic       opn_cs;
    logic       opl_cs;
    logic       oki_cs;
    logic       nmi_clr;
    logic       bank_we;
    logic       dev_cs;   // registered, matches dev_mux
    logic [7:0] dev_mux;
    logic       snreq_l;

    assign rom_cs  = |bus.addr[15:14]; // some games only decode bit 15
    assign bank_we = (BANKS != 0) && bus.addr[15] && !bus.rnw;
    assign ram_we  = ram_cs & ~bus.rnw;
    assign rdy     = ~rom_cs | rom_ok;
    assign irqn    = opn_irqn & opl_irqn;

    always_comb begin
        ram_cs  = 1'b0;
        opn_cs  = 1'b0;
        opl_cs  = 1'b0;
        oki_cs  = 1'b0;
        nmi_clr = 1'b0;
        if (!rom_cs) begin
            case (bus.addr[13:11])
                `SND_MAP_RAM:   ram_cs  = 1'b1;
                `SND_MAP_OPN:   opn_cs  = 1'b1;
                `SND_MAP_OPL:   opl_cs  = 1'b1;
                `SND_MAP_LATCH: nmi_clr = bus.rnw; // writes here are ignored
                `SND_MAP_OKI:   oki_cs  = 1'b1;
                default: ;
            endcase
        end
    end

    assign dev_sel = '{opn: opn_cs, opl: opl_cs, oki: oki_cs, oki_wrn: ~(oki_cs & ~bus.rnw)};

    // chip read data lines up with the RAM latency
    always_ff @(posedge clk) begin
        if (rst) begin
            dev_cs <= 1'b0;
        end else begin
            dev_cs <= opn_cs | opl_cs | oki_cs;
        end
    end

    always_ff @(posedge clk) begin
        dev_mux <= opn_cs ? dev_rd.opn :
                   opl_cs ? dev_rd.opl : dev_rd.oki;
    end

    always_comb begin
        cpu_din = rom_cs  ? rom_data :
                  ram_cs  ? ram_dout :
                  nmi_clr ? latch    :
                  dev_cs  ? dev_mux  : 8'hff; // open bus
    end

    // NMI on snreq rising edge, cleared by reading the latch
    always_ff @(posedge clk) begin
        if (rst) begin
            nmin    <= 1'b1;
            snreq_l <= 1'b0;
        end else begin
            snreq_l <= snreq;
            if (nmi_clr) begin
                nmin <= 1'b1; // clear wins over a new edge
            end else if (snreq && !snreq_l) begin
                nmin <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_bank <= 1'b0;
        end else if (bank_we) begin
            snd_bank <= bus.wdata[0];
        end
    end

endmodule

/* snd_cen_div.sv */
// divides cen_opl by three; output pulse lags its cen_opl pulse by one clock
module snd_cen_div (
    input  logic clk,
    input  logic rst,
    input  logic cen_opl,
    output logic cen_oki  // ~1 MHz for the ADPCM chip
);

    logic [2:0] ring; // one-hot phase

    always_ff @(posedge clk) begin
        if (rst) begin
            ring <= 3'b001;
        end else if (cen_opl) begin
            ring <= {ring[1:0], ring[2]};
        end
    end

    // fires on the pulse that sees phase zero
    always_ff @(posedge clk) begin
        if (rst) begin
            cen_oki <= 1'b0;
        end else begin
            cen_oki <= ring[0] & cen_opl;
        end
    end

endmodule

/* snd_ram.sv */
// single port work RAM, read-before-write, one clock read latency, contents not reset
`include "snd_consts.svh"

module snd_ram (
    input  logic                   clk,
    input  logic [`SND_RAM_AW-1:0] addr,
    input  logic [7:0]             din,
    input  logic                   we,
    output logic [7:0]             dout
);

    logic [7:0] mem [0:(1 << `SND_RAM_AW) - 1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr]; // old data on a write cycle
    end

endmodule

/* snd_dcrm.sv */
// DC remover for the 10-bit unsigned PSG; output stays in input LSB units, no gain applied
`include "snd_consts.svh"

module snd_dcrm import snd_audio_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic sample,
    input  psg_t din,
    output smp_t dout
);

    localparam int PW = $bits(psg_t) + `SND_DCRM_SHIFT; // average with fraction bits

    logic        [PW-1:0] avg;
    logic signed [PW:0]   diff;
    logic signed [PW:0]   step;

    // input scaled to the average's fixed point
    assign diff = $signed({1'b0, din, {`SND_DCRM_SHIFT{1'b0}}}) - $signed({1'b0, avg});
    assign step = diff >>> `SND_DCRM_SHIFT; // also the AC part in input units

    always_ff @(posedge clk) begin
        if (rst) begin
            avg  <= '0;
            dout <= '0;
        end else if (sample) begin
            avg  <= avg + step[PW-1:0]; // stays within 0..1023 scaled
            dout <= smp_t'(step);
        end
    end

endmodule

/* snd_mixer.sv */
// four channel mixer with 4.4 unsigned gains; sums wider than 16 bits clip and raise peak
module snd_mixer import snd_audio_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    input  mix_in_t   ch,
    input  gain_set_t gain,
    output smp_t      mixed,
    output logic      peak
);

    localparam int PRW = $bits(smp_t) + $bits(gain_t) + 1; // product width
    localparam int SUMW = PRW + 2;
    localparam logic signed [SUMW-1:0] MAXV = 32767;
    localparam logic signed [SUMW-1:0] MINV = -32768;

    logic signed [SUMW-1:0] sum;
    logic signed [SUMW-1:0] scaled;

    function automatic logic signed [PRW-1:0] apply_gain(smp_t x, gain_t g);
        logic signed [$bits(gain_t):0] gs;
        gs = $signed({1'b0, g}); // gain is never negative
        return x * gs;
    endfunction

    always_comb begin
        sum = apply_gain(ch.opn, gain.opn)
            + apply_gain(ch.opl, gain.opl)
            + apply_gain(ch.pcm, gain.pcm)
            + apply_gain(ch.psg, gain.psg);
        scaled = sum >>> 4; // drop the gain fraction
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mixed <= '0;
            peak  <= 1'b0;
        end else if (cen) begin
            if (scaled > MAXV) begin
                mixed <= smp_t'(MAXV);
                peak  <= 1'b1;
            end else if (scaled < MINV) begin
                mixed <= smp_t'(MINV);
                peak  <= 1'b1;
            end else begin
                mixed <= smp_t'(scaled);
                peak  <= 1'b0;
            end
        end
    end

endmodule

/* snd_top.sv */
// sound board glue; CPU and sound chips are external, samples and selects pass through ports
`include "snd_consts.svh"

module snd_top import snd_bus_pkg::*, snd_audio_pkg::*; #(
    parameter int BANKS = 0
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen_opn,
    input  logic       cen_opl,
    input  logic       enable_psg,
    input  logic       enable_fm,
    input  logic [1:0] fxlevel,
    input  logic       snreq,
    input  logic [7:0] latch,
    input  cpu_bus_t   bus,
    output logic [7:0] cpu_din,
    output logic       rdy,
    output logic       nmin,
    output logic       irqn,
    output logic [15:0] rom_addr,
    output logic       rom_cs,
    input  logic [7:0] rom_data,
    input  logic       rom_ok,
    output logic       snd_bank,
    output dev_sel_t   dev_sel,
    input  dev_rd_t    dev_rd,
    input  logic       opn_irqn,
    input  logic       opl_irqn,
    output logic       cen_oki,
    input  chan_in_t   chan,
    output smp_t       snd,
    output logic       sample,
    output logic       peak
);

    logic      ram_we;
    logic [7:0] ram_dout;
    gain_t     fx_gain;
    gain_set_t gain;
    smp_t      psg_ac;
    mix_in_t   mix_in;

    assign rom_addr = bus.addr;
    assign sample   = cen_opn;

    always_comb begin
        case (fxlevel)
            2'd0: fx_gain = `SND_FX_GAIN0;
            2'd1: fx_gain = `SND_FX_GAIN1;
            2'd2: fx_gain = `SND_FX_GAIN2;
            default: fx_gain = `SND_FX_GAIN3;
        endcase
    end

    // the OPN level follows enable_psg as on the original board
    assign gain = '{opn: enable_psg ? fx_gain : 8'h00,
                    opl: enable_fm ? `SND_OPL_GAIN : 8'h00,
                    pcm: `SND_PCM_GAIN,
                    psg: `SND_PSG_GAIN};

    assign mix_in = '{opn: chan.opn, opl: chan.opl, pcm: chan.adpcm, psg: psg_ac};

    snd_ctrl #(.BANKS(BANKS)) u_ctrl (
        .clk, .rst, .bus, .snreq, .latch, .rom_data, .rom_ok, .ram_dout, .dev_rd,
        .opn_irqn, .opl_irqn, .rom_cs, .ram_we, .dev_sel, .cpu_din, .rdy, .nmin,
        .irqn, .snd_bank
    );

    snd_cen_div u_cen_div (.clk, .rst, .cen_opl, .cen_oki);

    snd_ram u_ram (
        .clk, .addr(bus.addr[`SND_RAM_AW-1:0]), .din(bus.wdata), .we(ram_we), .dout(ram_dout)
    );

    snd_dcrm u_dcrm (.clk, .rst, .sample(cen_opn), .din(chan.psg), .dout(psg_ac));

    snd_mixer u_mixer (.clk, .rst, .cen(cen_opn), .ch(mix_in), .gain, .mixed(snd), .peak);

endmodule

/* snd_props.sv */
// concurrent checks bound into snd_top, sampled on clk; the last two are off during reset
module snd_props (
    input logic               clk,
    input logic               rst,
    input logic               nmin,
    input logic               rom_cs,
    input logic               ram_we,
    input logic               peak,
    input logic signed [15:0] snd
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0; // failed assertion count

    nmin_high_in_reset: assert property (@(posedge clk) rst |=> nmin)
        else begin
            fail_count++;
            $error("nmin low while in reset");
        end

    // rom region and ram write are exclusive decodes
    rom_ram_exclusive: assert property (@(posedge clk) disable iff (rst) !(rom_cs && ram_we))
        else begin
            fail_count++;
            $error("rom_cs and ram_we high together");
        end

    peak_at_limit: assert property (@(posedge clk) disable iff (rst)
        peak |-> (snd == 16'sh7fff || snd == 16'sh8000))
        else begin
            fail_count++;
            $error("peak set with snd off the limits");
        end

endmodule

bind snd_top snd_props i_props (
    .clk(clk), .rst(rst), .nmin(nmin), .rom_cs(rom_cs), .ram_we(ram_we),
    .peak(peak), .snd(snd)
);

/* snd_tb.sv */
// testbench for snd_top with BANKS=1; chips are modelled only as fixed read bytes and a low-byte ROM
`include "snd_consts.svh"

module snd_tb
    import snd_bus_pkg::*, snd_audio_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT  = 64;   // cycles allowed for any rdy wait
    localparam int DCRM_PULSES = 2000;

    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;
        logic [7:0]  wdata;
        logic [7:0]  exp_data; // only checked on reads
        logic [3:0]  exp_sel;  // opn, opl, oki, oki_wrn
        logic        exp_bank;
    } bus_op_t;

    typedef struct packed {
        logic signed [15:0] opn;
        logic signed [15:0] opl;
        logic signed [15:0] adpcm;
        logic [1:0]         fxlevel;
        logic               en_psg;
        logic               en_fm;
        logic signed [15:0] exp_snd;
        logic               exp_peak;
    } mix_vec_t;

    // device reads come back as a1 / b2 / c3, latch holds 5c
    localparam bus_op_t BUS_OPS [19] = '{
        '{16'h0012, 1'b0, 8'h5a, 8'h00, 4'b0001, 1'b0},  // ram write
        '{16'h07ff, 1'b0, 8'ha5, 8'h00, 4'b0001, 1'b0},
        '{16'h0012, 1'b1, 8'h00, 8'h5a, 4'b0001, 1'b0},  // ram read back
        '{16'h07ff, 1'b1, 8'h00, 8'ha5, 4'b0001, 1'b0},
        '{16'h4321, 1'b1, 8'h00, 8'h21, 4'b0001, 1'b0},  // rom read
        '{16'hff80, 1'b1, 8'h00, 8'h80, 4'b0001, 1'b0},
        '{16'h0801, 1'b1, 8'h00, 8'ha1, 4'b1001, 1'b0},  // opn
        '{16'h1000, 1'b1, 8'h00, 8'hb2, 4'b0101, 1'b0},  // opl
        '{16'h3800, 1'b1, 8'h00, 8'hc3, 4'b0011, 1'b0},  // oki read
        '{16'h3801, 1'b0, 8'h77, 8'h00, 4'b0010, 1'b0},  // oki write strobe low
        '{16'h1800, 1'b1, 8'h00, 8'hff, 4'b0001, 1'b0},  // unmapped
        '{16'h2400, 1'b1, 8'h00, 8'hff, 4'b0001, 1'b0},
        '{16'h3000, 1'b1, 8'h00, 8'h5c, 4'b0001, 1'b0},  // latch
        '{16'h8000, 1'b0, 8'h01, 8'h00, 4'b0001, 1'b1},  // bank set
        '{16'h0100, 1'b0, 8'h00, 8'h00, 4'b0001, 1'b1},
        '{16'h4000, 1'b0, 8'h00, 8'h00, 4'b0001, 1'b1},  // bit 15 clear, bank kept
        '{16'hc001, 1'b0, 8'hfe, 8'h00, 4'b0001, 1'b0},  // bank cleared
        '{16'h0100, 1'b1, 8'h00, 8'h00, 4'b0001, 1'b0},
        '{16'h3000, 1'b1, 8'h00, 8'h5c, 4'b0001, 1'b0}
    };

    localparam bus_op_t LATCH_RD = '{16'h3000, 1'b1, 8'h00, 8'h5c, 4'b0001, 1'b0};

    // expected values worked out by hand, psg held at 0
    localparam mix_vec_t MIX_VECS [12] = '{
        '{16'sd100, 16'sd200, 16'sd300, 2'd0, 1'b1, 1'b1, 16'sd650, 1'b0},
        '{16'sd1000, 16'sd0, 16'sd0, 2'd1, 1'b1, 1'b1, 16'sd2000, 1'b0},
        '{-16'sd1000, -16'sd500, 16'sd0, 2'd2, 1'b1, 1'b1, -16'sd3000, 1'b0},
        '{16'sd1000, 16'sd500, -16'sd200, 2'd3, 1'b0, 1'b1, 16'sd300, 1'b0},
        '{16'sd1000, 16'sd500, -16'sd200, 2'd3, 1'b1, 1'b0, 16'sd2800, 1'b0},
        '{-16'sd7, 16'sd0, 16'sd0, 2'd0, 1'b1, 1'b1, -16'sd11, 1'b0},   // floor on shift
        '{16'sd20000, 16'sd20000, 16'sd0, 2'd3, 1'b1, 1'b1, 16'sh7fff, 1'b1},
        '{16'sh8000, 16'sh8000, 16'sh8000, 2'd3, 1'b1, 1'b1, 16'sh8000, 1'b1},
        '{16'sd0, 16'sd32767, 16'sd0, 2'd0, 1'b1, 1'b1, 16'sd32767, 1'b0}, // at limit
        '{16'sd0, 16'sd32767, 16'sd1, 2'd0, 1'b1, 1'b1, 16'sh7fff, 1'b1},
        '{16'sd0, 16'sd0, 16'sd0, 2'd0, 1'b1, 1'b1, 16'sd0, 1'b0},
        '{16'sd30000, 16'sd30000, 16'sd30000, 2'd2, 1'b0, 1'b0, 16'sd30000, 1'b0}
    };

    logic       clk = 1'b0;
    logic       rst;
    logic       cen_opn;
    logic       cen_opl;
    logic       enable_psg;
    logic       enable_fm;
    logic [1:0] fxlevel;
    logic       snreq;
    logic [7:0] latch;
    cpu_bus_t   bus;
    logic [7:0] cpu_din;
    logic       rdy;
    logic       nmin;
    logic       irqn;
    logic [15:0] rom_addr;
    logic       rom_cs;
    logic [7:0] rom_data;
    logic       rom_ok;
    logic       snd_bank;
    dev_sel_t   dev_sel;
    dev_rd_t    dev_rd;
    logic       opn_irqn;
    logic       opl_irqn;
    logic       cen_oki;
    chan_in_t   chan;
    smp_t       snd;
    logic       sample;
    logic       peak;
    integer     seed = 32'h757c7348;

    always #50 clk = ~clk;

    assign rom_data = rom_addr[7:0]; // rom image is its own low address byte

    snd_top #(.BANKS(1)) i_snd_top (
        .clk, .rst, .cen_opn, .cen_opl, .enable_psg, .enable_fm, .fxlevel, .snreq, .latch,
        .bus, .cpu_din, .rdy, .nmin, .irqn, .rom_addr, .rom_cs, .rom_data, .rom_ok,
        .snd_bank, .dev_sel, .dev_rd, .opn_irqn, .opl_irqn, .cen_oki, .chan, .snd,
        .sample, .peak
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] time %0t: %s, got 0x%0h expected 0x%0h",
                               $time, what, got, exp));
        end
    endtask

    task automatic bus_idle();
        bus = '{addr: 16'h2800, wdata: 8'h00, rnw: 1'b1}; // unmapped read
    endtask

    // call on a falling edge; returns on the falling edge where rdy was seen high
    task automatic run_bus_op(input bus_op_t op, input string what);
        int   delay;
        int   waited;
        logic rom_region;
        logic got_rdy;
        rom_region = |op.addr[15:14];
        delay = $random(seed) & 7; // rom wait states for this cycle
        got_rdy = 1'b0;
        bus = '{addr: op.addr, wdata: op.wdata, rnw: op.rnw};
        rom_ok = 1'b0;
        for (waited = 0; waited < WAIT_LIMIT && !got_rdy; waited++) begin
            @(negedge clk);
            check_eq(rdy, !rom_region || rom_ok, {what, " rdy"});
            got_rdy = rdy;
            if (!got_rdy && waited >= delay) begin
                rom_ok = 1'b1;
            end
        end
        if (!got_rdy) begin
            fail_run({what, ": rdy never went high before the timeout"});
        end
        check_eq(rom_cs, rom_region, {what, " rom_cs"});
        check_eq(dev_sel, op.exp_sel, {what, " dev_sel"});
        if (op.rnw) begin
            check_eq(cpu_din, op.exp_data, {what, " read data"});
        end
        check_eq(snd_bank, op.exp_bank, {what, " snd_bank"});
    endtask

    initial begin
        int oki_count;
        int snd_mag;
        rst = 1'b1;
        cen_opn = 1'b0;
        cen_opl = 1'b0;
        enable_psg = 1'b1;
        enable_fm = 1'b1;
        fxlevel = 2'd0;
        snreq = 1'b0;
        latch = 8'h5c;
        bus_idle();
        rom_ok = 1'b0;
        dev_rd = '{opn: 8'ha1, opl: 8'hb2, oki: 8'hc3};
        opn_irqn = 1'b1;
        opl_irqn = 1'b1;
        chan = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        check_eq(nmin, 1'b1, "nmin after reset");
        check_eq(snd_bank, 1'b0, "snd_bank after reset");
        check_eq(snd, 16'h0000, "snd after reset");
        check_eq(peak, 1'b0, "peak after reset");
        check_eq(cen_oki, 1'b0, "cen_oki after reset");

        for (int i = 0; i < 19; i++) begin
            run_bus_op(BUS_OPS[i], $sformatf("bus op %0d", i));
        end
        bus_idle();

        // nmi edge, hold, clear
        snreq = 1'b1;
        @(negedge clk);
        check_eq(nmin, 1'b0, "nmin after snreq rise");
        repeat (4) begin
            @(negedge clk);
            check_eq(nmin, 1'b0, "nmin held low");
        end
        run_bus_op(LATCH_RD, "latch read");
        check_eq(nmin, 1'b1, "nmin cleared by latch read");
        bus_idle();
        repeat (4) begin
            @(negedge clk);
            check_eq(nmin, 1'b1, "no second edge while snreq held");
        end
        snreq = 1'b0;
        @(negedge clk);
        snreq = 1'b1;
        run_bus_op(LATCH_RD, "latch read on edge"); // clear beats the new edge
        check_eq(nmin, 1'b1, "latch read wins over edge");
        bus_idle();
        snreq = 1'b0;
        @(negedge clk);
        snreq = 1'b1;
        @(negedge clk);
        check_eq(nmin, 1'b0, "nmin after second rise");
        run_bus_op(LATCH_RD, "latch read again");
        check_eq(nmin, 1'b1, "nmin cleared again");
        bus_idle();

        for (int k = 0; k < 4; k++) begin
            opn_irqn = k[0];
            opl_irqn = k[1];
            @(negedge clk);
            check_eq(irqn, k[0] & k[1], "irqn merge");
        end

        // 30 cen_opl pulses, one every third clock
        oki_count = 0;
        for (int p = 0; p < 30; p++) begin
            for (int c = 0; c < 3; c++) begin
                cen_opl = (c == 0);
                @(negedge clk);
                if (cen_oki) begin
                    oki_count++;
                end
                if (c != 0) begin
                    check_eq(cen_oki, 1'b0, "cen_oki one clock wide");
                end
            end
        end
        cen_opl = 1'b0;
        check_eq(oki_count, 10, "cen_oki pulse count");

        for (int v = 0; v < 12; v++) begin
            chan = '{opn: MIX_VECS[v].opn, opl: MIX_VECS[v].opl,
                     adpcm: MIX_VECS[v].adpcm, psg: 10'd0};
            fxlevel = MIX_VECS[v].fxlevel;
            enable_psg = MIX_VECS[v].en_psg;
            enable_fm = MIX_VECS[v].en_fm;
            cen_opn = 1'b1;
            @(negedge clk);
            check_eq(sample, 1'b1, "sample follows cen_opn high");
            check_eq(snd, MIX_VECS[v].exp_snd, $sformatf("mix vector %0d snd", v));
            check_eq(peak, MIX_VECS[v].exp_peak, $sformatf("mix vector %0d peak", v));
            cen_opn = 1'b0;
            @(negedge clk);
            check_eq(sample, 1'b0, "sample follows cen_opn low");
            check_eq(snd, MIX_VECS[v].exp_snd, $sformatf("mix vector %0d hold", v));
            check_eq(peak, MIX_VECS[v].exp_peak, $sformatf("mix vector %0d peak hold", v));
        end

        // constant psg must settle to zero
        chan = '{opn: 16'sd0, opl: 16'sd0, adpcm: 16'sd0, psg: 10'd600};
        for (int n = 0; n < DCRM_PULSES; n++) begin
            cen_opn = 1'b1;
            @(negedge clk);
            cen_opn = 1'b0;
            @(negedge clk);
            if (n == 3) begin
                check_eq(snd > 16'sd100, 1'b1, "psg step reaches the mix");
            end
        end
        snd_mag = snd;
        if (snd_mag < 0) begin
            snd_mag = -snd_mag;
        end
        check_eq(snd_mag <= 2, 1'b1, "dc removed from psg");

        if (i_snd_top.i_props.fail_count != 0) begin
            fail_run("a bound assertion on snd_top failed during the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* filelist.f */
+incdir+.
snd_bus_pkg.sv
snd_audio_pkg.sv
snd_ctrl.sv
snd_cen_div.sv
snd_ram.sv
snd_dcrm.sv
snd_mixer.sv
snd_top.sv
snd_props.sv
snd_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= snd_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= test passed
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
